//--- dv/tb_fetch_ref.svh
// Fetch reference model
`ifndef TB_FETCH_REF_SVH
`define TB_FETCH_REF_SVH

////////////////////
// Random numbers
////////////////////

// TLB sets in the DUT
localparam int SETS_LOG2 = 7;

// LCG state, seed 17
logic [31:0] rnd = 32'd17;

function automatic logic [31:0] lcg_step(input logic [31:0] s);
   return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic logic [31:0] next_rand();
   rnd = lcg_step(rnd);
   return rnd;
endfunction

////////////////////
// Shadow state
////////////////////

// Memory image as loaded at boot
logic [XLEN-1:0] img [0:(1<<IMEM_AW)-1];
// TLB words as last written
logic [XLEN-1:0] shadow_lo [0:(1<<SETS_LOG2)-1];
logic [XLEN-1:0] shadow_hi [0:(1<<SETS_LOG2)-1];

// Expected response for one fetch
function automatic fetch_rsp_t expect_fetch(input logic [XLEN-1:0] va,
                                            input logic imme,
                                            input logic rm);
   fetch_rsp_t           r;
   tlb_lo_t              lo;
   tlb_hi_t              hi;
   logic [XLEN-1:0]      pa;
   logic [SETS_LOG2-1:0] set;
   logic                 deny;
   set         = va[PAGE_SHIFT +: SETS_LOG2];
   lo          = shadow_lo[set];
   hi          = shadow_hi[set];
   r.tag.vaddr = va;
   r.tag.exc   = EXC_NONE;
   pa          = va;
   if (imme) begin
      // Execute right for the sampled mode
      deny = rm ? !hi.rx : !hi.ux;
      pa   = {hi.ppn, va[PAGE_SHIFT-1:0]};
      if (deny) begin
         r.tag.exc = EXC_PAGE_FAULT;
      end else if (!lo.v || lo.vpn != va[XLEN-1:PAGE_SHIFT]) begin
         r.tag.exc = EXC_TLB_MISS;
      end
   end
   // Word index from byte address
   r.insn = img[pa[IMEM_AW+1:2]];
   return r;
endfunction

`endif

//--- dv/tb_fetch_mmu.sv
// Fetch MMU testbench
`timescale 1ns/1ps

module tb_fetch_mmu;

   import mmu_pkg::*;
   import ibus_pkg::*;

   `include "tb_fetch_ref.svh"

   // Cycle limits per wait
   localparam int CMD_TIMEOUT   = 200;
   localparam int DRAIN_TIMEOUT = 2000;

   logic            clk = 1'b0;
   logic            rst;
   logic            cmd_valid;
   logic            cmd_ready;
   logic [XLEN-1:0] cmd_vaddr;
   logic            psr_imme;
   logic            psr_rm;
   tlb_wr_t         tlb_lo_wr;
   tlb_wr_t         tlb_hi_wr;
   tlb_lo_t         tlb_lo_rd;
   tlb_hi_t         tlb_hi_rd;
   mem_load_t       mem_load;
   logic            rsp_valid;
   logic            rsp_ready = 1'b1;
   fetch_rsp_t      rsp;

   // Random rsp_ready when set
   logic            bp_on = 1'b0;
   logic [31:0]     bp_rnd = 32'd17;

   // Expected responses in issue order
   fetch_rsp_t       exp_q[$];
   logic [VPN_W-1:0] hit_vpn [0:7];
   int               errors = 0;
   int               checks = 0;
   int               accepted = 0;
   int               responses = 0;

   fetch_mmu_top #(.TLB_NSETS_LOG2(SETS_LOG2)) dut0 (.*);

   always #10 clk = ~clk;

   ////////////////////
   // Helpers
   ////////////////////

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
      checks++;
      if (got !== want) begin
         errors++;
         $display("Error at %0t: %s = %h, expected %h", $time, name, got, want);
      end
   endtask

   task automatic report_failure(input string msg);
      errors++;
      $display("Failure at %0t: %s", $time, msg);
   endtask

   task automatic test_done(input string name, input int mark);
      $display("Test %s: %0d errors", name, errors - mark);
   endtask

   // Random VPN that lands in the given set
   function automatic logic [VPN_W-1:0] vpn_for(input logic [SETS_LOG2-1:0] set);
      logic [31:0] r;
      r = next_rand();
      return {r[VPN_W-1:SETS_LOG2], set};
   endfunction

   task automatic load_word(input logic [IMEM_AW-1:0] idx, input logic [XLEN-1:0] word);
      #1;
      mem_load.we   = 1'b1;
      mem_load.idx  = idx;
      mem_load.data = word;
      img[idx]      = word;
      @(posedge clk);
   endtask

   task automatic write_tlb(input logic [SETS_LOG2-1:0] set, input logic [XLEN-1:0] lo,
                            input logic [XLEN-1:0] hi);
      #1;
      // No fetch while the TLB changes
      cmd_valid     = 1'b0;
      tlb_lo_wr.idx = TLB_IDX_W'(set);
      tlb_lo_wr.we  = 1'b1;
      tlb_lo_wr.nxt = lo;
      tlb_hi_wr.idx = TLB_IDX_W'(set);
      tlb_hi_wr.we  = 1'b1;
      tlb_hi_wr.nxt = hi;
      shadow_lo[set] = lo;
      shadow_hi[set] = hi;
      @(posedge clk);
      #1;
      tlb_lo_wr.we = 1'b0;
      tlb_hi_wr.we = 1'b0;
      @(posedge clk);
   endtask

   task automatic map_entry(input logic [VPN_W-1:0] vpn, input logic [31:0] r,
                            input logic v, input logic rx, input logic ux);
      tlb_lo_t lo;
      tlb_hi_t hi;
      lo     = '0;
      lo.vpn = vpn;
      lo.v   = v;
      hi     = '0;
      hi.ppn = r[PPN_W-1:0];
      hi.rx  = rx;
      hi.ux  = ux;
      hi.p   = 1'b1;
      write_tlb(vpn[SETS_LOG2-1:0], lo, hi);
   endtask

   // Readback word is registered one clock after the index
   task automatic readback(input logic [SETS_LOG2-1:0] set);
      #1;
      tlb_lo_wr.idx = TLB_IDX_W'(set);
      tlb_hi_wr.idx = TLB_IDX_W'(set);
      @(posedge clk);
      @(negedge clk);
      check("tlb_lo_rd", tlb_lo_rd, shadow_lo[set]);
      check("tlb_hi_rd", tlb_hi_rd, shadow_hi[set]);
      @(posedge clk);
   endtask

   // Offer one command, push its expected response on transfer
   task automatic fetch(input logic [XLEN-1:0] va, input logic imme, input logic rm);
      int   waited;
      logic done;
      waited = 0;
      done   = 1'b0;
      #1;
      cmd_valid = 1'b1;
      cmd_vaddr = va;
      psr_imme  = imme;
      psr_rm    = rm;
      while (!done && waited < CMD_TIMEOUT) begin
         @(negedge clk);
         done = cmd_ready;
         @(posedge clk);
         waited++;
      end
      if (done) begin
         exp_q.push_back(expect_fetch(va, imme, rm));
         accepted++;
      end else begin
         report_failure("timeout, cmd_ready never came");
      end
   endtask

   task automatic idle();
      #1;
      cmd_valid = 1'b0;
      @(posedge clk);
   endtask

   task automatic drain(input string name);
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
         @(posedge clk);
         waited++;
      end
      if (exp_q.size() != 0) begin
         report_failure($sformatf("timeout in %s, %0d responses never arrived",
                                  name, exp_q.size()));
         exp_q.delete();
      end
   endtask

   ////////////////////
   // Response side
   ////////////////////

   always @(posedge clk) begin
      #1;
      if (bp_on) begin
         bp_rnd    = lcg_step(bp_rnd);
         rsp_ready = bp_rnd[16];
      end else begin
         rsp_ready = 1'b1;
      end
   end

   // Mid-cycle sample, transfer lands on the next edge
   always @(negedge clk) begin : compare
      fetch_rsp_t want;
      if (!rst && rsp_valid && rsp_ready) begin
         responses++;
         if (exp_q.size() == 0) begin
            report_failure("response arrived with no command outstanding");
         end else begin
            want = exp_q.pop_front();
            check("rsp.insn", rsp.insn, want.insn);
            check("rsp.tag.vaddr", rsp.tag.vaddr, want.tag.vaddr);
            check("rsp.tag.exc", 32'(rsp.tag.exc), 32'(want.tag.exc));
         end
      end
   end

   ////////////////////
   // Stimulus
   ////////////////////

   initial begin : main
      int               mark;
      int               acc0;
      int               rsp0;
      logic [31:0]      r;
      logic [XLEN-1:0]  va;
      logic [VPN_W-1:0] vpn;
      rst       = 1'b1;
      cmd_valid = 1'b0;
      cmd_vaddr = '0;
      psr_imme  = 1'b0;
      psr_rm    = 1'b0;
      tlb_lo_wr = '0;
      tlb_hi_wr = '0;
      mem_load  = '0;
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;
      @(posedge clk);

      // Boot image, random word mixed with its index
      for (int i = 0; i < (1 << IMEM_AW); i++) begin
         load_word(IMEM_AW'(i), next_rand() ^ 32'(i));
      end
      #1;
      mem_load.we = 1'b0;
      @(posedge clk);

      // Identity map
      mark = errors;
      for (int i = 0; i < 32; i++) begin
         r = next_rand();
         fetch(next_rand(), 1'b0, r[16]);
      end
      idle();
      drain("translation off");
      test_done("translation off", mark);

      // Every set gets written, so later lookups are defined
      mark = errors;
      for (int i = 0; i < (1 << SETS_LOG2); i++) begin
         r = next_rand();
         write_tlb(SETS_LOG2'(i), r, lcg_step(r));
      end
      for (int i = 0; i < (1 << SETS_LOG2); i++) begin
         readback(SETS_LOG2'(i));
      end
      test_done("tlb readback", mark);

      // Hits in kernel and user mode
      mark = errors;
      for (int k = 0; k < 8; k++) begin
         hit_vpn[k] = vpn_for(SETS_LOG2'(10 + k));
         map_entry(hit_vpn[k], next_rand(), 1'b1, 1'b1, 1'b1);
      end
      for (int k = 0; k < 8; k++) begin
         r = next_rand();
         fetch({hit_vpn[k], r[PAGE_SHIFT-1:0]}, 1'b1, 1'b1);
         fetch({hit_vpn[k], r[31:19]}, 1'b1, 1'b0);
      end
      idle();
      drain("translation hit");
      test_done("translation hit", mark);

      mark = errors;
      // Invalid entry
      vpn = vpn_for(SETS_LOG2'(40));
      map_entry(vpn, next_rand(), 1'b0, 1'b1, 1'b1);
      fetch({vpn, 13'h0100}, 1'b1, 1'b1);
      // Stored VPN differs in its top bit
      vpn = vpn_for(SETS_LOG2'(41));
      map_entry(vpn, next_rand(), 1'b1, 1'b1, 1'b1);
      fetch({~vpn[VPN_W-1], vpn[VPN_W-2:0], 13'h0204}, 1'b1, 1'b0);
      // Kernel lacks rx, user still runs
      vpn = vpn_for(SETS_LOG2'(42));
      map_entry(vpn, next_rand(), 1'b1, 1'b0, 1'b1);
      fetch({vpn, 13'h0008}, 1'b1, 1'b1);
      fetch({vpn, 13'h000c}, 1'b1, 1'b0);
      // User lacks ux
      vpn = vpn_for(SETS_LOG2'(43));
      map_entry(vpn, next_rand(), 1'b1, 1'b1, 1'b0);
      fetch({vpn, 13'h1ff0}, 1'b1, 1'b0);
      fetch({vpn, 13'h1ff4}, 1'b1, 1'b1);
      // Denied and invalid together
      vpn = vpn_for(SETS_LOG2'(44));
      map_entry(vpn, next_rand(), 1'b0, 1'b0, 1'b1);
      fetch({vpn, 13'h0040}, 1'b1, 1'b1);
      idle();
      drain("faults");
      test_done("faults", mark);

      // Long back-to-back burst under random rsp_ready
      mark  = errors;
      acc0  = accepted;
      rsp0  = responses;
      bp_on = 1'b1;
      for (int i = 0; i < 200; i++) begin
         r  = next_rand();
         va = r[20] ? {hit_vpn[r[2:0]], r[31:19]} : next_rand();
         fetch(va, r[21] | r[20], r[22]);
      end
      idle();
      drain("back-pressure");
      bp_on = 1'b0;
      check("response count", 32'(responses - rsp0), 32'(accepted - acc0));
      test_done("back-pressure", mark);

      $display("Checks %0d, errors %0d, commands %0d, responses %0d",
               checks, errors, accepted, responses);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

//--- project.f
+incdir+dv
rtl/mmu_pkg.sv
rtl/ibus_pkg.sv
rtl/tlb_ram.sv
rtl/fetch_pipebuf.sv
rtl/immu.sv
rtl/insn_mem.sv
rtl/fetch_mmu_top.sv
dv/tb_fetch_mmu.sv

//--- rtl/fetch_mmu_top.sv
// Fetch translation subsystem top
`timescale 1ns/1ps

module fetch_mmu_top #(
   parameter int TLB_NSETS_LOG2 = 7
) (
   input  logic                     clk,
   input  logic                     rst,
   // Fetch command
   input  logic                     cmd_valid,
   output logic                     cmd_ready,
   input  logic [mmu_pkg::XLEN-1:0] cmd_vaddr,
   // Processor status
   input  logic                     psr_imme,
   input  logic                     psr_rm,
   // TLB register access
   input  mmu_pkg::tlb_wr_t         tlb_lo_wr,
   input  mmu_pkg::tlb_wr_t         tlb_hi_wr,
   output mmu_pkg::tlb_lo_t         tlb_lo_rd,
   output mmu_pkg::tlb_hi_t         tlb_hi_rd,
   // Boot load
   input  ibus_pkg::mem_load_t      mem_load,
   // Response
   output logic                     rsp_valid,
   input  logic                     rsp_ready,
   output ibus_pkg::fetch_rsp_t     rsp
);

   import ibus_pkg::*;

   // MMU to memory
   logic     mem_cmd_valid;
   logic     mem_cmd_ready;
   mem_cmd_t mem_cmd;

   immu #(.TLB_NSETS_LOG2(TLB_NSETS_LOG2)) u_immu (
      .clk           (clk),
      .rst           (rst),
      .cmd_valid     (cmd_valid),
      .cmd_ready     (cmd_ready),
      .cmd_vaddr     (cmd_vaddr),
      .psr_imme      (psr_imme),
      .psr_rm        (psr_rm),
      .mem_cmd_valid (mem_cmd_valid),
      .mem_cmd_ready (mem_cmd_ready),
      .mem_cmd       (mem_cmd),
      .tlb_lo_wr     (tlb_lo_wr),
      .tlb_hi_wr     (tlb_hi_wr),
      .tlb_lo_rd     (tlb_lo_rd),
      .tlb_hi_rd     (tlb_hi_rd)
   );

   insn_mem u_insn_mem (
      .clk           (clk),
      .rst           (rst),
      .mem_load      (mem_load),
      .mem_cmd_valid (mem_cmd_valid),
      .mem_cmd_ready (mem_cmd_ready),
      .mem_cmd       (mem_cmd),
      .rsp_valid     (rsp_valid),
      .rsp_ready     (rsp_ready),
      .rsp           (rsp)
   );

endmodule

//--- rtl/fetch_pipebuf.sv
// One-entry fetch command stage
`timescale 1ns/1ps

module fetch_pipebuf #(
   parameter int W = 32
) (
   input  logic         clk,
   input  logic         rst,
   // Upstream side
   input  logic         in_valid,
   output logic         in_ready,
   input  logic [W-1:0] in_data,
   // Downstream side
   output logic         out_valid,
   input  logic         out_ready,
   output logic [W-1:0] out_data,
   // Marks the input transfer
   output logic         accept
);

   logic         full;
   logic [W-1:0] data_q;

   // Free when empty or draining this cycle
   assign in_ready = ~full | out_ready;
   assign accept   = in_valid & in_ready;

   // Occupancy
   always_ff @(posedge clk) begin
      if (rst) begin
         full <= 1'b0;
      end else if (accept) begin
         full <= 1'b1;
      end else if (out_ready) begin
         full <= 1'b0;
      end
   end

   // Payload, loaded on accept only
   always_ff @(posedge clk) begin
      if (accept) begin
         data_q <= in_data;
      end
   end

   assign out_valid = full;
   assign out_data  = data_q;

   // Held command does not change under back-pressure
   a_out_hold: assert property (
      @(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> out_valid && $stable(out_data)
   );

endmodule

//--- rtl/ibus_pkg.sv
// Instruction fetch bus types
package ibus_pkg;

   // Word address width of the instruction memory
   localparam int IMEM_AW = 10;

   // Fault code carried with every fetch
   typedef enum logic [1:0] {
      EXC_NONE       = 2'd0,
      EXC_TLB_MISS   = 2'd1,
      EXC_PAGE_FAULT = 2'd2
   } fetch_exc_e;

   // Sideband that follows a request to its response
   typedef struct packed {
      logic [mmu_pkg::XLEN-1:0] vaddr;
      fetch_exc_e               exc;
   } fetch_tag_t;

   // Translated command towards memory
   typedef struct packed {
      logic [mmu_pkg::XLEN-1:0] paddr;
      fetch_tag_t               tag;
   } mem_cmd_t;

   // Instruction returned to the fetch unit
   typedef struct packed {
      logic [mmu_pkg::XLEN-1:0] insn;
      fetch_tag_t               tag;
   } fetch_rsp_t;

   // Boot write into instruction memory
   typedef struct packed {
      logic [IMEM_AW-1:0]       idx;
      logic [mmu_pkg::XLEN-1:0] data;
      logic                     we;
   } mem_load_t;

endpackage

//--- rtl/immu.sv
// Instruction MMU
`timescale 1ns/1ps

module immu #(
   parameter int TLB_NSETS_LOG2 = 7
) (
   input  logic                       clk,
   input  logic                       rst,
   // Fetch command
   input  logic                       cmd_valid,
   output logic                       cmd_ready,
   input  logic [mmu_pkg::XLEN-1:0]   cmd_vaddr,
   // Processor status
   input  logic                       psr_imme,
   input  logic                       psr_rm,
   // Memory command
   output logic                       mem_cmd_valid,
   input  logic                       mem_cmd_ready,
   output ibus_pkg::mem_cmd_t         mem_cmd,
   // TLB register access
   input  mmu_pkg::tlb_wr_t           tlb_lo_wr,
   input  mmu_pkg::tlb_wr_t           tlb_hi_wr,
   output mmu_pkg::tlb_lo_t           tlb_lo_rd,
   output mmu_pkg::tlb_hi_t           tlb_hi_rd
);

   import mmu_pkg::*;
   import ibus_pkg::*;

   logic                      accept;
   logic [XLEN-1:0]           vaddr_q;
   logic                      imme_q;
   logic                      rm_q;
   logic [TLB_NSETS_LOG2-1:0] lookup_idx;
   tlb_lo_t                   tlb_lo_q;
   tlb_hi_t                   tlb_hi_q;
   logic [VPN_W-1:0]          vpn_q;
   logic                      perm_denied;
   logic                      tlb_hit;
   fetch_exc_e                exc;
   logic [XLEN-1:0]           tlb_paddr;

   ////////////////////
   // Command stage
   ////////////////////

   // Holds the virtual address until memory takes it
   fetch_pipebuf #(.W(XLEN)) u_pipebuf (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (cmd_valid),
      .in_ready  (cmd_ready),
      .in_data   (cmd_vaddr),
      .out_valid (mem_cmd_valid),
      .out_ready (mem_cmd_ready),
      .out_data  (vaddr_q),
      .accept    (accept)
   );

   // Status sampled with the command
   always_ff @(posedge clk) begin
      if (rst) begin
         imme_q <= 1'b0;
         rm_q   <= 1'b0;
      end else if (accept) begin
         imme_q <= psr_imme;
         rm_q   <= psr_rm;
      end
   end

   ////////////////////
   // TLB arrays
   ////////////////////

   // Direct-mapped set from the low VPN bits
   assign lookup_idx = cmd_vaddr[PAGE_SHIFT +: TLB_NSETS_LOG2];

   // Low word with VPN and valid
   tlb_ram #(.AW(TLB_NSETS_LOG2), .DW(XLEN)) u_tlb_lo (
      .clk    (clk),
      .rst    (rst),
      .addr_a (lookup_idx),
      .re_a   (accept),
      .dout_a (tlb_lo_q),
      .addr_b (tlb_lo_wr.idx[TLB_NSETS_LOG2-1:0]),
      .we_b   (tlb_lo_wr.we),
      .din_b  (tlb_lo_wr.nxt),
      .dout_b (tlb_lo_rd)
   );

   // High word with PPN and permissions
   tlb_ram #(.AW(TLB_NSETS_LOG2), .DW(XLEN)) u_tlb_hi (
      .clk    (clk),
      .rst    (rst),
      .addr_a (lookup_idx),
      .re_a   (accept),
      .dout_a (tlb_hi_q),
      .addr_b (tlb_hi_wr.idx[TLB_NSETS_LOG2-1:0]),
      .we_b   (tlb_hi_wr.we),
      .din_b  (tlb_hi_wr.nxt),
      .dout_b (tlb_hi_rd)
   );

   ////////////////////
   // Decode
   ////////////////////

   assign vpn_q = vaddr_q[XLEN-1:PAGE_SHIFT];

   // Execute permission for the sampled mode
   assign perm_denied = rm_q ? ~tlb_hi_q.rx : ~tlb_hi_q.ux;
   assign tlb_hit     = tlb_lo_q.v && (tlb_lo_q.vpn == vpn_q);

   // Page fault wins over miss
   // Permission is checked even when the tag misses
   always_comb begin
      exc = EXC_NONE;
      if (imme_q) begin
         if (perm_denied) begin
            exc = EXC_PAGE_FAULT;
         end else if (!tlb_hit) begin
            exc = EXC_TLB_MISS;
         end
      end
   end

   // PPN joined with page offset
   assign tlb_paddr = {tlb_hi_q.ppn, vaddr_q[PAGE_SHIFT-1:0]};

   // Identity map with translation off
   always_comb begin
      mem_cmd.paddr     = imme_q ? tlb_paddr : vaddr_q;
      mem_cmd.tag.vaddr = vaddr_q;
      mem_cmd.tag.exc   = exc;
   end

   ////////////////////
   // Checks
   ////////////////////

   // Accepted command reaches memory next cycle
   a_cmd_to_mem: assert property (
      @(posedge clk) disable iff (rst)
      cmd_valid && cmd_ready |=> mem_cmd_valid
   );

   // TLB output and held address stay aligned under a stall
   a_mem_cmd_hold: assert property (
      @(posedge clk) disable iff (rst)
      mem_cmd_valid && !mem_cmd_ready |=> $stable(mem_cmd)
   );

endmodule

//--- rtl/insn_mem.sv
// Physical instruction memory
`timescale 1ns/1ps

module insn_mem (
   input  logic                 clk,
   input  logic                 rst,
   // Boot write port
   input  ibus_pkg::mem_load_t  mem_load,
   // Memory command
   input  logic                 mem_cmd_valid,
   output logic                 mem_cmd_ready,
   input  ibus_pkg::mem_cmd_t   mem_cmd,
   // Response
   output logic                 rsp_valid,
   input  logic                 rsp_ready,
   output ibus_pkg::fetch_rsp_t rsp
);

   import mmu_pkg::*;
   import ibus_pkg::*;

   logic [XLEN-1:0]    mem [0:(1<<IMEM_AW)-1];
   logic               rsp_full;
   logic               take;
   fetch_rsp_t         rsp_q;
   logic [IMEM_AW-1:0] word_idx;

   ////////////////////
   // Storage
   ////////////////////

   // Boot image load
   always_ff @(posedge clk) begin
      if (mem_load.we) begin
         mem[mem_load.idx] <= mem_load.data;
      end
   end

   ////////////////////
   // Response register
   ////////////////////

   // Free when empty or the held word leaves now
   assign mem_cmd_ready = ~rsp_full | rsp_ready;
   assign take          = mem_cmd_valid & mem_cmd_ready;

   // Word address from byte address
   assign word_idx = mem_cmd.paddr[IMEM_AW+1:2];

   always_ff @(posedge clk) begin
      if (rst) begin
         rsp_full <= 1'b0;
      end else if (take) begin
         rsp_full <= 1'b1;
      end else if (rsp_ready) begin
         rsp_full <= 1'b0;
      end
   end

   // Tag passes through untouched, faulted requests too
   always_ff @(posedge clk) begin
      if (take) begin
         rsp_q.insn <= mem[word_idx];
         rsp_q.tag  <= mem_cmd.tag;
      end
   end

   assign rsp_valid = rsp_full;
   assign rsp       = rsp_q;

   // Response frozen until taken
   a_rsp_hold: assert property (
      @(posedge clk) disable iff (rst)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp)
   );

endmodule

//--- rtl/mmu_pkg.sv
// MMU page geometry and TLB formats
package mmu_pkg;

   ////////////////////
   // Page geometry
   ////////////////////

   // Address and data width
   localparam int XLEN = 32;
   // 8 KiB pages
   localparam int PAGE_SHIFT = 13;
   // Page number widths
   localparam int VPN_W = XLEN - PAGE_SHIFT;
   localparam int PPN_W = XLEN - PAGE_SHIFT;
   // Register index width, upper bits ignored for smaller TLBs
   localparam int TLB_IDX_W = 8;

   ////////////////////
   // TLB entry words
   ////////////////////

   // Low word, tag side
   typedef struct packed {
      logic [VPN_W-1:0]        vpn;
      logic [XLEN-VPN_W-2:0]   rsv;
      logic                    v;
   } tlb_lo_t;

   // High word, translation and permissions
   typedef struct packed {
      logic [PPN_W-1:0] ppn;
      logic [7:0]       rsv_hi;
      // Kernel execute
      logic             rx;
      // User execute
      logic             ux;
      logic [1:0]       rsv_lo;
      logic             p;
   } tlb_hi_t;

   // Register access to one TLB half
   typedef struct packed {
      logic [TLB_IDX_W-1:0] idx;
      logic                 we;
      logic [XLEN-1:0]      nxt;
   } tlb_wr_t;

endpackage

//--- rtl/tlb_ram.sv
// Two-port TLB RAM
`timescale 1ns/1ps

module tlb_ram #(
   parameter int AW = 7,
   parameter int DW = 32
) (
   input  logic          clk,
   input  logic          rst,
   // Lookup port
   input  logic [AW-1:0] addr_a,
   input  logic          re_a,
   output logic [DW-1:0] dout_a,
   // Register port
   input  logic [AW-1:0] addr_b,
   input  logic          we_b,
   input  logic [DW-1:0] din_b,
   output logic [DW-1:0] dout_b
);

   // Entry storage, no reset
   logic [DW-1:0] mem [0:(1<<AW)-1];

   ////////////////////
   // Port A
   ////////////////////

   // Read only on request
   // Output holds the entry while the stage stalls
   always_ff @(posedge clk) begin
      if (re_a) begin
         dout_a <= mem[addr_a];
      end
   end

   ////////////////////
   // Port B
   ////////////////////

   // Write on enable, read back every cycle
   // Same-cycle read returns the old word
   always_ff @(posedge clk) begin
      if (we_b) begin
         mem[addr_b] <= din_b;
      end
      dout_b <= mem[addr_b];
   end

   ////////////////////
   // Checks
   ////////////////////

   // Looked-up entry only moves on a new read
   a_dout_a_hold: assert property (
      @(posedge clk) disable iff (rst)
      !re_a |=> $stable(dout_a)
   );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the fetch MMU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f project.f --top-module tb_fetch_mmu -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

# Result is decided by the log
if grep -q "Verification failed" sim.log; then
   exit 1
fi
exit 0
